// File: Makefile
# Verilator build and run for the pipelined ALU

VERILATOR ?= verilator
TOP       ?= alu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL TESTS PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status comes from the search for the pass message
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/alu_decode.sv
// decode stage: select code to unit, adder operand forming, registered decoded op
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inValid,
  input  logic [`ALU_WIDTH-1:0] a,
  input  logic [`ALU_WIDTH-1:0] b,
  input  alu_pkg::aluOpE        sel,
  output alu_pkg::decodedOpT    dec
);

  import alu_pkg::*;

  decodedOpT decNext;

  always_comb
  begin
    decNext              = '0;
    decNext.valid        = inValid;
    decNext.illegal      = 1'b0;
    decNext.unit         = unitLogic;
    decNext.op           = sel;
    decNext.opA          = a;
    decNext.opB          = b;
    decNext.addB         = b;
    decNext.carryIn      = 1'b0;
    decNext.keepCarry    = 1'b0;
    decNext.shiftOperand = a;

    case (sel)
      opAdd:
      begin
        decNext.unit      = unitAdd;
        decNext.keepCarry = 1'b1;
      end
      // a + ~b + 1
      opSub:
      begin
        decNext.unit    = unitAdd;
        decNext.addB    = ~b;
        decNext.carryIn = 1'b1;
      end
      opInc:
      begin
        decNext.unit    = unitAdd;
        decNext.addB    = '0;
        decNext.carryIn = 1'b1;
      end
      // a + all ones wraps to a - 1
      opDec:
      begin
        decNext.unit = unitAdd;
        decNext.addB = '1;
      end
      opMul:
        decNext.unit = unitMul;
      opShr:
      begin
        decNext.unit         = unitShift;
        decNext.shiftOperand = a;
      end
      opShl:
      begin
        decNext.unit         = unitShift;
        decNext.shiftOperand = b;
      end
      // no divider in this build
      opDiv, opMod:
        decNext.illegal = 1'b1;
      default:
        decNext.unit = unitLogic;
    endcase
  end

  always_ff @(posedge clk)
  begin
    dec <= decNext;
    if (rst)
    begin
      dec.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/alu_execute.sv
// execute stage: adder, Booth multiplier, logic and shift units, registered outputs
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_execute (
  input  logic               clk,
  input  logic               rst,
  input  alu_pkg::decodedOpT dec,
  output alu_pkg::execOutT   exec
);

  import alu_pkg::*;

  logic [`ALU_WIDTH-1:0]        sumLow;
  logic                         sumCarry;
  logic [`ALU_RESULT_WIDTH-1:0] product;
  logic [`ALU_WIDTH-1:0]        logicOut;
  logic [`ALU_WIDTH-1:0]        shiftOut;
  execOutT                      execNext;

  // shared by add, subtract, increment and decrement
  ripple_adder #(
    .width(`ALU_WIDTH)
  ) adderInst (
    .x(dec.opA),
    .y(dec.addB),
    .carryIn(dec.carryIn),
    .sum(sumLow),
    .carryOut(sumCarry)
  );

  booth_multiplier mulInst (
    .multiplicand(dec.opA),
    .multiplier(dec.opB),
    .product(product)
  );

  always_comb
  begin
    case (dec.op)
      opAnd:   logicOut = dec.opA & dec.opB;
      opOr:    logicOut = dec.opA | dec.opB;
      opNot:   logicOut = ~dec.opA;
      opNand:  logicOut = ~(dec.opA & dec.opB);
      opNor:   logicOut = ~(dec.opA | dec.opB);
      opXor:   logicOut = dec.opA ^ dec.opB;
      opXnor:  logicOut = ~(dec.opA ^ dec.opB);
      default: logicOut = '0;
    endcase
  end

  // top bit falls off on the left shift
  always_comb
  begin
    case (dec.op)
      opShr:   shiftOut = dec.shiftOperand >> 1;
      opShl:   shiftOut = dec.shiftOperand << 1;
      default: shiftOut = '0;
    endcase
  end

  always_comb
  begin
    execNext           = '0;
    execNext.valid     = dec.valid;
    execNext.illegal   = dec.illegal;
    execNext.keepCarry = dec.keepCarry;
    execNext.unit      = dec.unit;
    execNext.sum       = {sumCarry, sumLow};
    execNext.product   = product;
    execNext.logicOut  = logicOut;
    execNext.shiftOut  = shiftOut;
  end

  always_ff @(posedge clk)
  begin
    exec <= execNext;
    if (rst)
    begin
      exec.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/alu_pkg.sv
// ALU operation and unit enums, decode and execute stage structs
`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

  typedef enum logic [`ALU_SEL_WIDTH-1:0] {
    opSub  = `ALU_SEL_SUB,
    opAdd  = `ALU_SEL_ADD,
    opMul  = `ALU_SEL_MUL,
    opDiv  = `ALU_SEL_DIV,
    opAnd  = `ALU_SEL_AND,
    opOr   = `ALU_SEL_OR,
    opNot  = `ALU_SEL_NOT,
    opNand = `ALU_SEL_NAND,
    opNor  = `ALU_SEL_NOR,
    opShr  = `ALU_SEL_SHR,
    opShl  = `ALU_SEL_SHL,
    opXor  = `ALU_SEL_XOR,
    opXnor = `ALU_SEL_XNOR,
    opMod  = `ALU_SEL_MOD,
    opInc  = `ALU_SEL_INC,
    opDec  = `ALU_SEL_DEC
  } aluOpE;

  typedef enum logic [1:0] {
    unitAdd,
    unitMul,
    unitLogic,
    unitShift
  } unitE;

  // decode stage output
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    unitE                  unit;
    aluOpE                 op;
    logic [`ALU_WIDTH-1:0] opA;
    logic [`ALU_WIDTH-1:0] opB;
    logic [`ALU_WIDTH-1:0] addB;
    logic                  carryIn;
    logic                  keepCarry;
    logic [`ALU_WIDTH-1:0] shiftOperand;
  } decodedOpT;

  // execute stage output, one field per unit
  typedef struct packed {
    logic                         valid;
    logic                         illegal;
    logic                         keepCarry;
    unitE                         unit;
    logic [`ALU_WIDTH:0]          sum;
    logic [`ALU_RESULT_WIDTH-1:0] product;
    logic [`ALU_WIDTH-1:0]        logicOut;
    logic [`ALU_WIDTH-1:0]        shiftOut;
  } execOutT;

endpackage

`default_nettype wire

// File: design/alu_result.sv
// result stage: unit output select, zero extension to 64 bits, output registers
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_result (
  input  logic                         clk,
  input  logic                         rst,
  input  alu_pkg::execOutT             exec,
  output logic                         outValid,
  output logic                         illegal,
  output logic [`ALU_RESULT_WIDTH-1:0] result
);

  import alu_pkg::*;

  logic [`ALU_RESULT_WIDTH-1:0] resultNext;

  always_comb
  begin
    case (exec.unit)
      unitAdd:
      begin
        // carry only kept for plain add
        if (exec.keepCarry)
          resultNext = `ALU_RESULT_WIDTH'(exec.sum);
        else
          resultNext = `ALU_RESULT_WIDTH'(exec.sum[`ALU_WIDTH-1:0]);
      end
      unitMul:   resultNext = exec.product;
      unitLogic: resultNext = `ALU_RESULT_WIDTH'(exec.logicOut);
      default:   resultNext = `ALU_RESULT_WIDTH'(exec.shiftOut);
    endcase
    if (exec.illegal)
      resultNext = '0;
  end

  always_ff @(posedge clk)
  begin
    result  <= resultNext;
    illegal <= exec.illegal;
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= exec.valid;
  end

endmodule

`default_nettype wire

// File: design/alu_top.sv
// three-stage pipelined ALU top level
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         inValid,
  input  logic [`ALU_WIDTH-1:0]        a,
  input  logic [`ALU_WIDTH-1:0]        b,
  input  alu_pkg::aluOpE               sel,
  output logic                         outValid,
  output logic [`ALU_RESULT_WIDTH-1:0] result,
  output logic                         illegal
);

  import alu_pkg::*;

  decodedOpT decBus;
  execOutT   execBus;

  alu_decode decodeInst (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .a(a),
    .b(b),
    .sel(sel),
    .dec(decBus)
  );

  alu_execute executeInst (
    .clk(clk),
    .rst(rst),
    .dec(decBus),
    .exec(execBus)
  );

  alu_result resultInst (
    .clk(clk),
    .rst(rst),
    .exec(execBus),
    .outValid(outValid),
    .illegal(illegal),
    .result(result)
  );

endmodule

`default_nettype wire

// File: design/booth_multiplier.sv
// radix-4 modified Booth signed multiplier, 32x32 to 64-bit product
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module booth_multiplier (
  input  logic [`ALU_WIDTH-1:0]        multiplicand,
  input  logic [`ALU_WIDTH-1:0]        multiplier,
  output logic [`ALU_RESULT_WIDTH-1:0] product
);

  localparam int rows    = `ALU_BOOTH_ROWS;
  localparam int ppWidth = `ALU_WIDTH + 1;
  localparam int extBits = `ALU_RESULT_WIDTH - ppWidth;

  // implicit zero below bit 0 for the first group
  logic [`ALU_WIDTH:0] padded;
  logic [ppWidth-1:0]  mulOne;
  logic [ppWidth-1:0]  mulTwo;

  // partial products kept in ones complement, +1 added through neg
  logic [ppWidth-1:0] pp [rows];
  logic [rows-1:0]    neg;

  assign padded = {multiplier, 1'b0};
  assign mulOne = {multiplicand[`ALU_WIDTH-1], multiplicand};
  assign mulTwo = {multiplicand, 1'b0};

  always_comb
  begin
    logic [2:0] grp;

    for (int i = 0; i < rows; i++)
    begin
      grp = padded[2*i +: 3];
      case (grp)
        3'b001, 3'b010:
        begin
          pp[i]  = mulOne;
          neg[i] = 1'b0;
        end
        3'b011:
        begin
          pp[i]  = mulTwo;
          neg[i] = 1'b0;
        end
        3'b100:
        begin
          pp[i]  = ~mulTwo;
          neg[i] = 1'b1;
        end
        3'b101, 3'b110:
        begin
          pp[i]  = ~mulOne;
          neg[i] = 1'b1;
        end
        default:
        begin
          pp[i]  = '0;
          neg[i] = 1'b0;
        end
      endcase
    end
  end

  // sign-extended rows at shifts 0, 2, ... 30
  always_comb
  begin
    logic [`ALU_RESULT_WIDTH-1:0] acc;

    acc = '0;
    for (int i = 0; i < rows; i++)
    begin
      acc = acc + ({{extBits{pp[i][ppWidth-1]}}, pp[i]} << (2 * i));
      acc = acc + (`ALU_RESULT_WIDTH'(neg[i]) << (2 * i));
    end
    product = acc;
  end

endmodule

`default_nettype wire

// File: design/ripple_adder.sv
// parameterized ripple-carry adder built from full-adder cells
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module ripple_adder #(
  parameter int width = `ALU_WIDTH
) (
  input  logic [width-1:0] x,
  input  logic [width-1:0] y,
  input  logic             carryIn,
  output logic [width-1:0] sum,
  output logic             carryOut
);

  // carry[i] enters cell i
  logic [width:0] carry;

  assign carry[0] = carryIn;

  for (genvar i = 0; i < width; i++)
  begin : gCell
    assign sum[i]       = x[i] ^ y[i] ^ carry[i];
    assign carry[i + 1] = (x[i] & y[i]) | (y[i] & carry[i]) | (x[i] & carry[i]);
  end

  assign carryOut = carry[width];

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/alu_pkg.sv
design/ripple_adder.sv
design/booth_multiplier.sv
design/alu_decode.sv
design/alu_execute.sv
design/alu_result.sv
design/alu_top.sv
verif/alu_tb.sv

// File: include/alu_consts.svh
// ALU operand, result and select widths, Booth row count and select codes
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define ALU_WIDTH 32
`define ALU_RESULT_WIDTH 64
`define ALU_SEL_WIDTH 4
`define ALU_BOOTH_ROWS 16

// select codes
`define ALU_SEL_SUB 4'd0
`define ALU_SEL_ADD 4'd1
`define ALU_SEL_MUL 4'd2
`define ALU_SEL_DIV 4'd3
`define ALU_SEL_AND 4'd4
`define ALU_SEL_OR 4'd5
`define ALU_SEL_NOT 4'd6
`define ALU_SEL_NAND 4'd7
`define ALU_SEL_NOR 4'd8
`define ALU_SEL_SHR 4'd9
`define ALU_SEL_SHL 4'd10
`define ALU_SEL_XOR 4'd11
`define ALU_SEL_XNOR 4'd12
`define ALU_SEL_MOD 4'd13
`define ALU_SEL_INC 4'd14
`define ALU_SEL_DEC 4'd15

`endif

// File: verif/alu_tb.sv
// ALU testbench with clock, reset, corner and random stimulus, reference model, scoreboard, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_tb;

  import alu_pkg::*;

  localparam int clkPeriod   = 100;
  localparam int numCorner   = 5;
  localparam int numDirected = 16 * numCorner * numCorner;
  localparam int numRandom   = 2000;
  // about two cycles per item covers the idle gaps, plus reset and drain
  localparam int timeoutNs   = (2 * (numDirected + numRandom) + 100) * clkPeriod;

  typedef struct packed {
    logic [`ALU_RESULT_WIDTH-1:0] result;
    logic                         illegal;
    logic [3:0]                   code;
    logic [31:0]                  sampleEdge;
  } expectT;

  logic                         clk;
  logic                         rst;
  logic                         inValid;
  logic [`ALU_WIDTH-1:0]        a;
  logic [`ALU_WIDTH-1:0]        b;
  aluOpE                        sel;
  logic                         outValid;
  logic [`ALU_RESULT_WIDTH-1:0] result;
  logic                         illegal;

  expectT                pending [$];
  logic [31:0]           edgeCount;
  integer                seed;
  int                    errors;
  int                    checks;
  logic [`ALU_WIDTH-1:0] corners [numCorner];

  alu_top alu_top_inst (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .a(a),
    .b(b),
    .sel(sel),
    .outValid(outValid),
    .result(result),
    .illegal(illegal)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    edgeCount <= edgeCount + 1;
  end

  // expected result straight from the operation rules
  function automatic expectT modelOp(input logic [3:0] code, input logic [31:0] x,
                                     input logic [31:0] y);
    expectT             e;
    logic signed [63:0] sx;
    logic signed [63:0] sy;
    e      = '0;
    e.code = code;
    sx     = {{32{x[31]}}, x};
    sy     = {{32{y[31]}}, y};
    case (code)
      `ALU_SEL_SUB:  e.result = {32'd0, x - y};
      `ALU_SEL_ADD:  e.result = {31'd0, {1'b0, x} + {1'b0, y}};
      `ALU_SEL_MUL:  e.result = sx * sy;
      `ALU_SEL_DIV:  e.illegal = 1'b1;
      `ALU_SEL_AND:  e.result = {32'd0, x & y};
      `ALU_SEL_OR:   e.result = {32'd0, x | y};
      `ALU_SEL_NOT:  e.result = {32'd0, ~x};
      `ALU_SEL_NAND: e.result = {32'd0, ~(x & y)};
      `ALU_SEL_NOR:  e.result = {32'd0, ~(x | y)};
      `ALU_SEL_SHR:  e.result = {32'd0, x >> 1};
      `ALU_SEL_SHL:  e.result = {32'd0, y << 1};
      `ALU_SEL_XOR:  e.result = {32'd0, x ^ y};
      `ALU_SEL_XNOR: e.result = {32'd0, ~(x ^ y)};
      `ALU_SEL_MOD:  e.illegal = 1'b1;
      `ALU_SEL_INC:  e.result = {32'd0, x + 32'd1};
      `ALU_SEL_DEC:  e.result = {32'd0, x - 32'd1};
    endcase
    return e;
  endfunction

  // mostly random with one in eight from the corner list
  function automatic logic [31:0] pickOperand();
    int idx;
    if (($random(seed) & 7) == 0)
    begin
      idx = ($random(seed) & 32'h7fffffff) % numCorner;
      return corners[idx];
    end
    return $random(seed);
  endfunction

  task automatic driveItem(input logic v, input logic [3:0] code, input logic [31:0] x,
                           input logic [31:0] y);
    @(posedge clk);
    inValid <= v;
    sel     <= aluOpE'(code);
    a       <= x;
    b       <= y;
  endtask

  // outputs and next-edge inputs are both stable at the falling edge
  always @(negedge clk)
  begin : scoreboard
    expectT exp;
    if (outValid)
    begin
      if (pending.size() == 0)
      begin
        errors++;
        $display("outValid high at %0t with no item in flight", $time);
      end
      else
      begin
        exp = pending.pop_front();
        checks++;
        if (edgeCount != exp.sampleEdge + 2)
        begin
          errors++;
          $display("[FAIL] %0t: sel %0d result after edge %0d, expected after edge %0d",
                   $time, exp.code, edgeCount, exp.sampleEdge + 2);
        end
        if (result !== exp.result)
        begin
          errors++;
          $display("[FAIL] %0t: sel %0d result %h, expected %h",
                   $time, exp.code, result, exp.result);
        end
        if (illegal !== exp.illegal)
        begin
          errors++;
          $display("[FAIL] %0t: sel %0d illegal %b, expected %b",
                   $time, exp.code, illegal, exp.illegal);
        end
      end
    end
    else if (pending.size() != 0 && edgeCount >= pending[0].sampleEdge + 2)
    begin
      exp = pending.pop_front();
      errors++;
      $display("result for sel %0d sampled at edge %0d never came out (time %0t)",
               exp.code, exp.sampleEdge, $time);
    end
    // the coming reset edge clears every stage
    if (rst)
      pending.delete();
    if (inValid && !rst)
    begin
      exp            = modelOp(sel, a, b);
      exp.sampleEdge = edgeCount + 1;
      pending.push_back(exp);
    end
  end

  initial
  begin
    int sent;
    int roll;
    seed       = 32'h4253deef;
    errors     = 0;
    checks     = 0;
    edgeCount  = '0;
    rst        = 1'b1;
    inValid    = 1'b0;
    a          = '0;
    b          = '0;
    sel        = opAdd;
    corners[0] = 32'h00000000;
    corners[1] = 32'hffffffff;
    corners[2] = 32'h80000000;
    corners[3] = 32'h7fffffff;
    corners[4] = 32'h00000001;

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // quiet pipeline before the first item
    repeat (4) driveItem(1'b0, 4'd0, 32'd0, 32'd0);

    // every code against every corner pair back to back
    for (int code = 0; code < 16; code++)
    begin
      for (int i = 0; i < numCorner; i++)
      begin
        for (int j = 0; j < numCorner; j++)
        begin
          driveItem(1'b1, 4'(code), corners[i], corners[j]);
        end
      end
    end

    // reset pulse while the pipeline is full
    repeat (3) driveItem(1'b1, 4'($random(seed)), pickOperand(), pickOperand());
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    rst <= 1'b0;

    sent = 0;
    while (sent < numRandom)
    begin
      roll = ($random(seed) & 32'h7fffffff) % 10;
      if (roll < 8)
      begin
        driveItem(1'b1, 4'($random(seed)), pickOperand(), pickOperand());
        sent++;
      end
      else
        driveItem(1'b0, 4'($random(seed)), pickOperand(), pickOperand());
    end
    driveItem(1'b0, 4'd0, 32'd0, 32'd0);

    while (pending.size() != 0)
      @(posedge clk);
    repeat (5) @(posedge clk);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    #(timeoutNs);
    $display("watchdog timeout after %0d ns with %0d items in flight",
             timeoutNs, pending.size());
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
